// File: systolic_core.f
rtl/mac_pkg.sv
rtl/act_skew.sv
rtl/mac_pe.sv
rtl/pe_array.sv
rtl/psum_deskew.sv
rtl/result_accum.sv
rtl/systolic_core.sv
bench/clk_gen.sv
bench/systolic_core_chk.sv
bench/tb_systolic_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_systolic_core -f systolic_core.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "No errors" \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// File: bench/tb_systolic_core.sv
`timescale 1ns/1ns

module tb_systolic_core import mac_pkg::*; ();

  localparam int N_SINGLE  = 8;
  localparam int N_ACC     = 24;
  localparam int N_RELOAD  = 12;
  localparam int N_FILL    = 6;
  localparam int DRAIN_CYC = ARRAY_LAT + Q_DEPTH + 4;
  localparam int LIMIT = 10 + ROWS + N_SINGLE * (DRAIN_CYC + 1)
                       + N_ACC + 6 + DRAIN_CYC
                       + ROWS + N_RELOAD + DRAIN_CYC
                       + N_FILL + 2 * DRAIN_CYC
                       + 12 + DRAIN_CYC + 200;

  logic     clk;
  logic     rst_n;
  act_vec_t act;
  wgt_vec_t wgt;
  logic     rd_en;
  acc_row_t acc_data;
  logic     empty;
  logic     overflow;
  logic     busy;

  integer   seed;
  int       cycles;
  int       checks;
  int       errors;
  int       t_checks;
  int       t_errors;
  bit       drain_on;
  bit       finished;
  bit       exp_ovf;

  // reference model state
  int       wm [ROWS][COLS];
  int       acc_m [COLS];
  acc_row_t exp_q [$];

  clk_gen u_clk (.clk(clk));

  systolic_core dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .act     (act),
    .wgt     (wgt),
    .rd_en   (rd_en),
    .acc_data(acc_data),
    .empty   (empty),
    .overflow(overflow),
    .busy    (busy)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Errors found");
      finished = 1'b1;
      $finish;
    end
  end

  final begin
    if (!finished) begin
      $display("Run stopped before the end of the tests");
      $display("Errors found");
    end
  end

  task automatic clear_model();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        wm[r][c] = 0;
      end
    end
    for (int c = 0; c < COLS; c++) begin
      acc_m[c] = 0;
    end
    exp_q.delete();
    exp_ovf = 1'b0;
  endtask

  task automatic expect_flag(input logic got, input logic want, input string what);
    checks++;
    assert (got === want) else begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
      errors++;
    end
  endtask

  // compare the queue head and pop it on the next edge
  task automatic pop_and_compare();
    rd_en = 1'b0;
    if (drain_on && !empty) begin
      if (exp_q.size() == 0) begin
        $display("Result came out at %0t but none was expected", $time);
        errors++;
      end else begin
        checks++;
        assert (acc_data == exp_q[0]) else begin
          $display("[ERROR] %0t: result %h, expected %h", $time, acc_data, exp_q[0]);
          errors++;
        end
        void'(exp_q.pop_front());
      end
      rd_en = 1'b1;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    pop_and_compare();
  endtask

  task automatic send_vector(input acc_op_e op, input bit valid);
    int       prod;
    acc_row_t row;
    next_cycle();
    wgt.load  = 1'b0;
    act.valid = valid;
    act.op    = op;
    for (int r = 0; r < ROWS; r++) begin
      act.data[r] = A_W'($random(seed));
    end
    if (valid) begin
      for (int c = 0; c < COLS; c++) begin
        prod = 0;
        for (int r = 0; r < ROWS; r++) begin
          prod += int'($signed(act.data[r])) * wm[r][c];
        end
        if (op == ACC_LOAD || op == ACC_LOAD_PUSH) begin
          acc_m[c] = prod;
        end else begin
          acc_m[c] = acc_m[c] + prod;
        end
        row[c] = acc_m[c];
      end
      if (op == ACC_ADD_PUSH || op == ACC_LOAD_PUSH) begin
        // a full queue drops the row
        if (!drain_on && exp_q.size() >= Q_DEPTH) begin
          exp_ovf = 1'b1;
        end else begin
          exp_q.push_back(row);
        end
      end
    end
  endtask

  task automatic load_weight_row();
    next_cycle();
    act.valid = 1'b0;
    wgt.load  = 1'b1;
    for (int c = 0; c < COLS; c++) begin
      wgt.w[c] = W_W'($random(seed));
    end
    for (int r = ROWS - 1; r > 0; r--) begin
      for (int c = 0; c < COLS; c++) begin
        wm[r][c] = wm[r-1][c];
      end
    end
    for (int c = 0; c < COLS; c++) begin
      wm[0][c] = int'($signed(wgt.w[c]));
    end
  endtask

  task automatic load_matrix();
    repeat (ROWS) load_weight_row();
  endtask

  task automatic wait_drained();
    next_cycle();
    act.valid = 1'b0;
    wgt.load  = 1'b0;
    while (busy || (drain_on && !empty)) begin
      next_cycle();
    end
  endtask

  task automatic start_test();
    t_checks = checks;
    t_errors = errors;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
  endtask

  initial begin
    int sent;
    int run;
    seed     = 32'hffdea32c;
    cycles   = 0;
    checks   = 0;
    errors   = 0;
    drain_on = 1'b1;
    finished = 1'b0;
    rst_n    = 1'b0;
    act      = '0;
    wgt      = '0;
    rd_en    = 1'b0;
    clear_model();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    expect_flag(empty, 1'b1, "empty");
    expect_flag(busy, 1'b0, "busy");
    expect_flag(overflow, 1'b0, "overflow");

    start_test();
    load_matrix();
    for (int i = 0; i < N_SINGLE; i++) begin
      send_vector(ACC_LOAD_PUSH, 1'b1);
      wait_drained();
    end
    finish_test("test 1 single products");

    // load-opened runs closed by an add-push at one vector per cycle
    start_test();
    sent = 0;
    while (sent < N_ACC) begin
      run = 1 + ($random(seed) & 3);
      send_vector((($random(seed) & 1) != 0) ? ACC_LOAD_PUSH : ACC_LOAD, 1'b1);
      repeat (run) send_vector(ACC_ADD, 1'b1);
      send_vector(ACC_ADD_PUSH, 1'b1);
      sent += run + 2;
    end
    wait_drained();
    finish_test("test 2 accumulation");

    start_test();
    load_matrix();
    for (int i = 0; i < N_RELOAD; i++) begin
      send_vector(acc_op_e'(2'($random(seed))), ($random(seed) & 3) != 0);
    end
    wait_drained();
    finish_test("test 3 weight reload");

    start_test();
    expect_flag(overflow, exp_ovf, "overflow before the fill");
    drain_on = 1'b0;
    repeat (N_FILL) begin
      send_vector((($random(seed) & 1) != 0) ? ACC_ADD_PUSH : ACC_LOAD_PUSH, 1'b1);
    end
    wait_drained();
    expect_flag(overflow, exp_ovf, "overflow");
    drain_on = 1'b1;
    wait_drained();
    expect_flag(empty, exp_q.size() == 0, "empty");
    expect_flag(overflow, 1'b1, "overflow after draining");
    finish_test("test 4 queue fill and overflow");

    // weights and accumulator return to zero on a second reset
    start_test();
    next_cycle();
    rst_n = 1'b0;
    clear_model();
    repeat (10) next_cycle();
    rst_n = 1'b1;
    expect_flag(empty, 1'b1, "empty");
    expect_flag(busy, 1'b0, "busy");
    expect_flag(overflow, 1'b0, "overflow");
    send_vector(ACC_ADD_PUSH, 1'b1);
    wait_drained();
    expect_flag(empty, exp_q.size() == 0, "empty after reads");
    finish_test("test 5 reset values and empty state");

    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out of the queue", exp_q.size());
      errors++;
    end
    $display("all tests done: %0d checks, %0d errors", checks, errors);
    finished = 1'b1;
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: bench/systolic_core_chk.sv
`timescale 1ns/1ns

module systolic_core_chk import mac_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input act_vec_t act,
  input wgt_vec_t wgt,
  input logic     rd_en,
  input logic     empty,
  input logic     overflow,
  input logic     busy
);

  // flags on the first edge after reset release
  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> empty && !overflow && !busy)
    else $error("queue flags wrong after reset");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> !empty)
    else $error("rd_en high while the queue is empty");

  a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
    wgt.load |-> !act.valid && !busy)
    else $error("weight load while vectors are in flight");

  // lone push into an empty queue with nothing else in the pipeline
  a_push_latency: assert property (@(posedge clk) disable iff (!rst_n)
    act.valid && (act.op == ACC_ADD_PUSH || act.op == ACC_LOAD_PUSH) && empty && !busy
    |-> ##(ROWS+COLS-1) empty ##1 !empty)
    else $error("empty did not fall ROWS+COLS cycles after a push");

endmodule

bind systolic_core systolic_core_chk chk0 (
  .clk     (clk),
  .rst_n   (rst_n),
  .act     (act),
  .wgt     (wgt),
  .rd_en   (rd_en),
  .empty   (empty),
  .overflow(overflow),
  .busy    (busy)
);

// File: bench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // 40 ns period
  always begin
    #20;
    clk = ~clk;
  end

endmodule

// File: rtl/systolic_core.sv
`timescale 1ns/1ns

module systolic_core import mac_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  act_vec_t act,
  input  wgt_vec_t wgt,
  input  logic     rd_en,
  output acc_row_t acc_data,
  output logic     empty,
  output logic     overflow,
  output logic     busy
);

  act_data_t act_sk;
  psum_vec_t psum_raw;
  psum_vec_t psum_al;

  act_skew u_skew (
    .clk     (clk),
    .rst_n   (rst_n),
    .act_data(act.data),
    .act_skew(act_sk)
  );

  pe_array u_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .act_skew(act_sk),
    .wgt     (wgt),
    .psum    (psum_raw)
  );

  psum_deskew u_deskew (
    .clk     (clk),
    .rst_n   (rst_n),
    .psum_in (psum_raw),
    .psum_out(psum_al)
  );

  // valid and op bypass the array and are delayed inside
  result_accum u_accum (
    .clk      (clk),
    .rst_n    (rst_n),
    .vec_valid(act.valid),
    .vec_op   (act.op),
    .psum     (psum_al),
    .rd_en    (rd_en),
    .acc_data (acc_data),
    .empty    (empty),
    .overflow (overflow),
    .busy     (busy)
  );

endmodule

// File: rtl/result_accum.sv
`timescale 1ns/1ns

module result_accum import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      vec_valid,
  input  acc_op_e   vec_op,
  input  psum_vec_t psum,
  input  logic      rd_en,
  output acc_row_t  acc_data,
  output logic      empty,
  output logic      overflow,
  output logic      busy
);

  logic [ARRAY_LAT-1:0] v_dly;
  acc_op_e              op_dly [ARRAY_LAT];

  logic     vld;
  acc_op_e  op;
  logic     push;
  logic     pop;
  logic     full;
  logic     do_push;
  acc_row_t acc_q;
  acc_row_t acc_nxt;

  acc_row_t         mem [Q_DEPTH];
  logic [Q_AW-1:0]  wr_ptr;
  logic [Q_AW-1:0]  rd_ptr;
  logic [Q_AW:0]    count;

  // valid and op ride alongside the array
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_dly <= '0;
    end else begin
      v_dly <= {v_dly[ARRAY_LAT-2:0], vec_valid};
    end
  end

  always_ff @(posedge clk) begin
    op_dly[0] <= vec_op;
    for (int k = 1; k < ARRAY_LAT; k++) begin
      op_dly[k] <= op_dly[k-1];
    end
  end

  assign vld  = v_dly[ARRAY_LAT-1];
  assign op   = op_dly[ARRAY_LAT-1];
  assign busy = |v_dly;

  // sign-extend each column sum, then add or overwrite
  always_comb begin
    for (int c = 0; c < COLS; c++) begin
      if (op == ACC_LOAD || op == ACC_LOAD_PUSH) begin
        acc_nxt[c] = {{(ACC_W-P_W){psum.p[c][P_W-1]}}, psum.p[c]};
      end else begin
        acc_nxt[c] = acc_q[c] + {{(ACC_W-P_W){psum.p[c][P_W-1]}}, psum.p[c]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (vld) begin
      acc_q <= acc_nxt;
    end
  end

  assign push    = vld && (op == ACC_ADD_PUSH || op == ACC_LOAD_PUSH);
  assign full    = (count == Q_DEPTH);
  assign empty   = (count == '0);
  assign pop     = rd_en && !empty;
  assign do_push = push && !full;

  // queue storage holds the updated row, not the old one
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= acc_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  // first-word-fall-through head
  assign acc_data = mem[rd_ptr];

endmodule

// File: rtl/psum_deskew.sv
`timescale 1ns/1ns

module psum_deskew import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  psum_vec_t psum_in,
  output psum_vec_t psum_out
);

  // column c is COLS-1-c cycles early, so it waits that long
  for (genvar c = 0; c < COLS; c++) begin : g_col
    localparam int DEPTH = COLS - 1 - c;

    if (DEPTH == 0) begin : g_direct
      assign psum_out.p[c] = psum_in.p[c];
    end else begin : g_delay
      logic [DEPTH-1:0][P_W-1:0] dly;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          dly <= '0;
        end else begin
          dly[0] <= psum_in.p[c];
          for (int k = 1; k < DEPTH; k++) begin
            dly[k] <= dly[k-1];
          end
        end
      end

      assign psum_out.p[c] = dly[DEPTH-1];
    end
  end

endmodule

// File: rtl/pe_array.sv
`timescale 1ns/1ns

module pe_array import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  act_data_t act_skew,
  input  wgt_vec_t  wgt,
  output psum_vec_t psum
);

  // outputs of each cell
  logic [A_W-1:0] a_pass [ROWS][COLS];
  logic [P_W-1:0] p_pass [ROWS][COLS];
  logic [W_W-1:0] w_pass [ROWS][COLS];

  for (genvar r = 0; r < ROWS; r++) begin : g_r
    for (genvar c = 0; c < COLS; c++) begin : g_c
      logic [A_W-1:0] a_in;
      logic [P_W-1:0] p_in;
      logic [W_W-1:0] w_in;

      // activations enter at the left edge
      if (c == 0) begin : g_a_edge
        assign a_in = act_skew[r];
      end else begin : g_a_mid
        assign a_in = a_pass[r][c-1];
      end

      // top row starts from zero, weights enter here too
      if (r == 0) begin : g_top
        assign p_in = '0;
        assign w_in = wgt.w[c];
      end else begin : g_below
        assign p_in = p_pass[r-1][c];
        assign w_in = w_pass[r-1][c];
      end

      mac_pe u_pe (
        .clk   (clk),
        .rst_n (rst_n),
        .w_load(wgt.load),
        .w_in  (w_in),
        .w_out (w_pass[r][c]),
        .a_in  (a_in),
        .a_out (a_pass[r][c]),
        .p_in  (p_in),
        .p_out (p_pass[r][c])
      );
    end
  end

  // bottom row holds the finished column sums
  for (genvar c = 0; c < COLS; c++) begin : g_out
    assign psum.p[c] = p_pass[ROWS-1][c];
  end

endmodule

// File: rtl/mac_pe.sv
`timescale 1ns/1ns

module mac_pe import mac_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  w_load,
  input  logic signed [W_W-1:0] w_in,
  output logic signed [W_W-1:0] w_out,
  input  logic signed [A_W-1:0] a_in,
  output logic signed [A_W-1:0] a_out,
  input  logic signed [P_W-1:0] p_in,
  output logic signed [P_W-1:0] p_out
);

  logic signed [W_W-1:0] w_q;

  // stationary weight, also the next stage of the shift chain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_q <= '0;
    end else if (w_load) begin
      w_q <= w_in;
    end
  end

  assign w_out = w_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_out <= '0;
      p_out <= '0;
    end else begin
      a_out <= a_in;
      // operands sign-extended to P_W before the multiply
      p_out <= p_in + a_in * w_q;
    end
  end

endmodule

// File: rtl/act_skew.sv
`timescale 1ns/1ns

module act_skew import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  act_data_t act_data,
  output act_data_t act_skew
);

  // row r goes through r registers
  for (genvar r = 0; r < ROWS; r++) begin : g_row
    if (r == 0) begin : g_direct
      assign act_skew[r] = act_data[r];
    end else begin : g_delay
      logic [r-1:0][A_W-1:0] dly;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          dly <= '0;
        end else begin
          dly[0] <= act_data[r];
          for (int k = 1; k < r; k++) begin
            dly[k] <= dly[k-1];
          end
        end
      end

      assign act_skew[r] = dly[r-1];
    end
  end

endmodule

// File: rtl/mac_pkg.sv
package mac_pkg;

  // array geometry
  localparam int ROWS = 4;
  localparam int COLS = 4;

  // data widths
  localparam int A_W   = 8;
  localparam int W_W   = 8;
  localparam int P_W   = 20;
  localparam int ACC_W = 32;

  // result queue
  localparam int Q_DEPTH = 4;
  localparam int Q_AW    = $clog2(Q_DEPTH);

  // sample edge to aligned column sums
  localparam int ARRAY_LAT = ROWS + COLS - 1;

  // bit 1 pushes, bit 0 overwrites
  typedef enum logic [1:0] {
    ACC_ADD       = 2'd0,
    ACC_LOAD      = 2'd1,
    ACC_ADD_PUSH  = 2'd2,
    ACC_LOAD_PUSH = 2'd3
  } acc_op_e;

  typedef logic [ROWS-1:0][A_W-1:0] act_data_t;

  typedef struct packed {
    logic      valid;
    acc_op_e   op;
    act_data_t data;
  } act_vec_t;

  typedef struct packed {
    logic                     load;
    logic [COLS-1:0][W_W-1:0] w;
  } wgt_vec_t;

  typedef struct packed {
    logic [COLS-1:0][P_W-1:0] p;
  } psum_vec_t;

  typedef logic [COLS-1:0][ACC_W-1:0] acc_row_t;

endpackage
